// File: Makefile
VERILATOR ?= verilator
TOP       ?= ex_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/ex_tb.sv
// testbench for the execute stage
// directed table of ops with expected results, then random
// logic and add/sub ops checked against a reference model

`timescale 1ns/1ps
`default_nettype none

module ex_tb;
    import ex_types_pkg::*;
    import ex_op_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 10;
    localparam int N_RAND     = 40;
    localparam int MAX_LAT    = 6;   // cycles to wait for valid_o

    typedef struct {
        aluop_e    op;
        word_t     r1;
        word_t     r2;
        reg_addr_t wd;
        logic      wreg;
        word_t     e_wdata;
        logic      e_wreg;
        logic      e_ov;
        logic      e_whilo;
        word_t     e_hi;
        word_t     e_lo;
    } vec_t;

    logic      clk = 1'b0;
    logic      rst_n_i;
    logic      valid_i;
    aluop_e    aluop_i;
    word_t     reg1_i;
    word_t     reg2_i;
    reg_addr_t wd_i;
    logic      wreg_i;
    logic      valid_o;
    reg_addr_t wd_o;
    logic      wreg_o;
    word_t     wdata_o;
    logic      whilo_o;
    word_t     hi_o;
    word_t     lo_o;
    logic      overflow_o;
    logic      stall_o;

    vec_t        vecs[$];
    logic        table_ready = 1'b0;
    int unsigned lcg_state   = 35732;

    ex_top u_dut (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .aluop_i    (aluop_i),
        .reg1_i     (reg1_i),
        .reg2_i     (reg2_i),
        .wd_i       (wd_i),
        .wreg_i     (wreg_i),
        .valid_o    (valid_o),
        .wd_o       (wd_o),
        .wreg_o     (wreg_o),
        .wdata_o    (wdata_o),
        .whilo_o    (whilo_o),
        .hi_o       (hi_o),
        .lo_o       (lo_o),
        .overflow_o (overflow_o),
        .stall_o    (stall_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp_v, act_v);
            stop_run();
        end
    endtask

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // reference for the random ops, overflow when the wide result does not fit
    function automatic word_t model_alu(input aluop_e op, input word_t a, input word_t b,
                                        output logic ov);
        longint sa;
        longint sb;
        longint r;
        word_t  res;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ov = 1'b0;
        case (op)
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_NOR:  res = ~(a | b);
            default: begin
                r   = (op inside {OP_SUB, OP_SUBU}) ? sa - sb : sa + sb;
                res = r[31:0];
                ov  = (op inside {OP_ADD, OP_SUB}) && (r != longint'($signed(res)));
            end
        endcase
        return res;
    endfunction

    task automatic add_vec(input aluop_e op, input word_t r1, input word_t r2,
                           input reg_addr_t wd, input logic wreg, input word_t e_wdata,
                           input logic e_wreg, input logic e_ov, input logic e_whilo,
                           input word_t e_hi, input word_t e_lo);
        vec_t v;
        v.op      = op;
        v.r1      = r1;
        v.r2      = r2;
        v.wd      = wd;
        v.wreg    = wreg;
        v.e_wdata = e_wdata;
        v.e_wreg  = e_wreg;
        v.e_ov    = e_ov;
        v.e_whilo = e_whilo;
        v.e_hi    = e_hi;
        v.e_lo    = e_lo;
        vecs.push_back(v);
    endtask

    // called on a falling edge, returns on the falling edge that shows the result
    task automatic apply_vec(input vec_t v);
        logic mac;
        int   lat;
        mac     = v.op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
        valid_i = 1'b1;
        aluop_i = v.op;
        reg1_i  = v.r1;
        reg2_i  = v.r2;
        wd_i    = v.wd;
        wreg_i  = v.wreg;
        lat     = 0;
        do begin
            @(negedge clk);
            valid_i = 1'b0;
            lat     = lat + 1;
            check_val("stall_o", 64'(mac && lat == 1), 64'(stall_o));
        end while (!valid_o && lat < MAX_LAT);
        if (!valid_o) begin
            $display("valid_o never came back after issuing %s", v.op.name());
            stop_run();
        end
        check_val("latency", mac ? 64'd2 : 64'd1, 64'(lat));
        check_val("wdata_o", 64'(v.e_wdata), 64'(wdata_o));
        check_val("wd_o", 64'(v.wd), 64'(wd_o));
        check_val("wreg_o", 64'(v.e_wreg), 64'(wreg_o));
        check_val("overflow_o", 64'(v.e_ov), 64'(overflow_o));
        check_val("whilo_o", 64'(v.e_whilo), 64'(whilo_o));
        check_val("hi_o", 64'(v.e_hi), 64'(hi_o));
        check_val("lo_o", 64'(v.e_lo), 64'(lo_o));
    endtask

    initial begin
        vec_t        rv;
        word_t       sel;
        logic        rov;
        rst_n_i = 1'b0;
        valid_i = 1'b0;
        aluop_i = OP_NOP;
        reg1_i  = '0;
        reg2_i  = '0;
        wd_i    = '0;
        wreg_i  = 1'b0;

        // HI/LO straight out of reset
        add_vec(OP_MFHI,  32'h0, 32'h0, 5'd1, 1'b1, 32'h0, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_MFLO,  32'h0, 32'h0, 5'd2, 1'b1, 32'h0, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_AND,   32'hf0f0_1234, 32'h0ff0_ff00, 5'd3, 1'b1,
                32'h00f0_1200, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_OR,    32'hf0f0_1234, 32'h0ff0_ff00, 5'd4, 1'b1,
                32'hfff0_ff34, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_XOR,   32'hf0f0_1234, 32'h0ff0_ff00, 5'd5, 1'b1,
                32'hff00_ed34, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_NOR,   32'hf0f0_1234, 32'h0ff0_ff00, 5'd6, 1'b1,
                32'h000f_00cb, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_SLL,   32'h0000_0004, 32'h8000_00f1, 5'd7, 1'b1,
                32'h0000_0f10, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_SRL,   32'h0000_0008, 32'h8000_1200, 5'd8, 1'b1,
                32'h0080_0012, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_SRA,   32'h0000_0008, 32'h8000_1200, 5'd9, 1'b1,
                32'hff80_0012, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_SRA,   32'h0000_0024, 32'h7000_0000, 5'd10, 1'b1,  // only reg1[4:0] counts
                32'h0700_0000, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_ADD,   32'h0000_0005, 32'h0000_0007, 5'd11, 1'b1,
                32'h0000_000c, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_ADD,   32'h7fff_ffff, 32'h0000_0001, 5'd12, 1'b1,
                32'h8000_0000, 1'b0, 1'b1, 1'b0, 32'h0, 32'h0);
        add_vec(OP_ADDU,  32'h7fff_ffff, 32'h0000_0001, 5'd13, 1'b1,
                32'h8000_0000, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_SUB,   32'h8000_0000, 32'h0000_0001, 5'd14, 1'b1,
                32'h7fff_ffff, 1'b0, 1'b1, 1'b0, 32'h0, 32'h0);
        add_vec(OP_SUBU,  32'h8000_0000, 32'h0000_0001, 5'd15, 1'b1,
                32'h7fff_ffff, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_SUB,   32'h0000_0003, 32'h0000_0005, 5'd16, 1'b1,
                32'hffff_fffe, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_SLT,   32'hffff_ffff, 32'h0000_0001, 5'd17, 1'b1,
                32'h0000_0001, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_SLTU,  32'hffff_ffff, 32'h0000_0001, 5'd18, 1'b1,
                32'h0000_0000, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_SLT,   32'h8000_0000, 32'h7fff_ffff, 5'd19, 1'b1,
                32'h0000_0001, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_CLZ,   32'h0000_0000, 32'h0, 5'd20, 1'b1,
                32'h0000_0020, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_CLO,   32'hffff_ffff, 32'h0, 5'd21, 1'b1,
                32'h0000_0020, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_CLZ,   32'h0001_0000, 32'h0, 5'd22, 1'b1,
                32'h0000_000f, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_CLO,   32'hf000_0000, 32'h0, 5'd23, 1'b1,
                32'h0000_0004, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        // -2 * 3, then HI read through the bypass
        add_vec(OP_MULT,  32'hffff_fffe, 32'h0000_0003, 5'd24, 1'b0,
                32'hffff_fffa, 1'b0, 1'b0, 1'b1, 32'hffff_ffff, 32'hffff_fffa);
        add_vec(OP_MFHI,  32'h0, 32'h0, 5'd25, 1'b1,
                32'hffff_ffff, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_MULTU, 32'hffff_fffe, 32'h0000_0003, 5'd26, 1'b0,
                32'hffff_fffa, 1'b0, 1'b0, 1'b1, 32'h0000_0002, 32'hffff_fffa);
        add_vec(OP_MFLO,  32'h0, 32'h0, 5'd27, 1'b1,
                32'hffff_fffa, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_MUL,   32'hffff_fffd, 32'h0000_0007, 5'd28, 1'b1,
                32'hffff_ffeb, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_MULT,  32'h8000_0000, 32'h8000_0000, 5'd29, 1'b0,
                32'h0000_0000, 1'b0, 1'b0, 1'b1, 32'h4000_0000, 32'h0000_0000);
        // accumulate chain on a freshly written pair
        add_vec(OP_MTHI,  32'h0000_0001, 32'h0, 5'd30, 1'b0,
                32'h0, 1'b0, 1'b0, 1'b1, 32'h0000_0001, 32'h0000_0000);
        add_vec(OP_MTLO,  32'h0000_0010, 32'h0, 5'd31, 1'b0,
                32'h0, 1'b0, 1'b0, 1'b1, 32'h0000_0001, 32'h0000_0010);
        add_vec(OP_MADD,  32'h0000_0100, 32'hffff_ffff, 5'd1, 1'b0,
                32'h0, 1'b0, 1'b0, 1'b1, 32'h0000_0000, 32'hffff_ff10);
        add_vec(OP_MSUB,  32'h0000_0010, 32'h0000_0020, 5'd2, 1'b0,
                32'h0, 1'b0, 1'b0, 1'b1, 32'h0000_0000, 32'hffff_fd10);
        add_vec(OP_MADDU, 32'hffff_ffff, 32'h0000_0002, 5'd3, 1'b0,
                32'h0, 1'b0, 1'b0, 1'b1, 32'h0000_0002, 32'hffff_fd0e);
        add_vec(OP_MSUBU, 32'h0000_0003, 32'h0000_0001, 5'd4, 1'b0,
                32'h0, 1'b0, 1'b0, 1'b1, 32'h0000_0002, 32'hffff_fd0b);
        add_vec(OP_MFLO,  32'h0, 32'h0, 5'd5, 1'b1,
                32'hffff_fd0b, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        add_vec(OP_MFHI,  32'h0, 32'h0, 5'd6, 1'b1,
                32'h0000_0002, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        table_ready = 1'b1;

        repeat (RST_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
        check_val("valid_o", 64'd0, 64'(valid_o));  // idle after reset
        check_val("stall_o", 64'd0, 64'(stall_o));
        check_val("wreg_o", 64'd0, 64'(wreg_o));
        check_val("whilo_o", 64'd0, 64'(whilo_o));
        check_val("overflow_o", 64'd0, 64'(overflow_o));

        foreach (vecs[i]) begin
            apply_vec(vecs[i]);
        end

        for (int i = 0; i < N_RAND; i++) begin
            sel = lcg_next();
            case (sel[18:16])
                3'd0:    rv.op = OP_AND;
                3'd1:    rv.op = OP_OR;
                3'd2:    rv.op = OP_XOR;
                3'd3:    rv.op = OP_NOR;
                3'd4:    rv.op = OP_ADD;
                3'd5:    rv.op = OP_ADDU;
                3'd6:    rv.op = OP_SUB;
                default: rv.op = OP_SUBU;
            endcase
            rv.r1      = lcg_next();
            rv.r2      = lcg_next();
            rv.wd      = sel[4:0];
            rv.wreg    = sel[8];
            rv.e_wdata = model_alu(rv.op, rv.r1, rv.r2, rov);
            rv.e_ov    = rov;
            rv.e_wreg  = rv.wreg && !rov;  // overflow drops the write
            rv.e_whilo = 1'b0;
            rv.e_hi    = '0;
            rv.e_lo    = '0;
            apply_vec(rv);
        end

        @(negedge clk);
        check_val("valid_o", 64'd0, 64'(valid_o));  // result lasts one cycle
        check_val("stall_o", 64'd0, 64'(stall_o));
        $display("Regression passed");
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat ((vecs.size() + N_RAND) * 4 + 20) @(posedge clk);
        $display("watchdog expired before all ops were checked");
        stop_run();
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/ex_types_pkg.sv
verilog/ex_op_pkg.sv
verilog/ex_result_if.sv
verilog/alu_int.sv
verilog/mul_unit.sv
verilog/hilo_file.sv
verilog/ex_result_stage.sv
verilog/ex_top.sv
verif/ex_tb.sv

// File: verilog/alu_int.sv
// integer ALU of the execute stage
// logic, shift, add/sub/compare and leading zero/one count,
// plus signed overflow for add and sub; purely combinational

`timescale 1ns/1ps
`default_nettype none

module alu_int (
    input  ex_op_pkg::aluop_e   aluop_i,
    input  ex_types_pkg::word_t reg1_i,
    input  ex_types_pkg::word_t reg2_i,
    output ex_types_pkg::word_t logic_res_o,
    output ex_types_pkg::word_t shift_res_o,
    output ex_types_pkg::word_t arith_res_o,
    output logic                ov_o
);
    import ex_types_pkg::*;
    import ex_op_pkg::*;

    logic               sub_op;
    word_t              reg2_mux;   // reg2 or its negation
    word_t              sum;
    logic               b_sign;     // sign of the effective second operand
    logic               lt_signed;
    logic               lt_unsigned;
    logic [SHAMT_W-1:0] shamt;
    logic [5:0]         lead_cnt;
    logic [WORD_W:0]    wide_sum;   // sign-extended add/sub, one bit wider

    // priority search from the msb, 32 when no one is found
    function automatic logic [5:0] lead_zeros(input word_t v);
        logic [5:0] n;
        logic       hit;
        n   = 6'd0;
        hit = 1'b0;
        for (int i = WORD_W - 1; i >= 0; i--) begin
            if (!hit && !v[i]) begin
                n = n + 6'd1;
            end else begin
                hit = 1'b1;
            end
        end
        return n;
    endfunction

    assign sub_op      = aluop_i inside {OP_SUB, OP_SUBU, OP_SLT};

    assign reg2_mux = sub_op ? (~reg2_i + 32'd1) : reg2_i;
    assign sum      = reg1_i + reg2_mux;  // shared adder

    // overflow when both operands agree in sign and the sum does not
    assign b_sign = sub_op ? ~reg2_i[WORD_W-1] : reg2_i[WORD_W-1];
    assign ov_o   = (aluop_i inside {OP_ADD, OP_SUB})
                    && (reg1_i[WORD_W-1] == b_sign)
                    && (sum[WORD_W-1] != reg1_i[WORD_W-1]);

    // same-sign difference cannot overflow so its sign decides
    assign lt_signed = (reg1_i[WORD_W-1] && !reg2_i[WORD_W-1])
                       || ((reg1_i[WORD_W-1] == reg2_i[WORD_W-1]) && sum[WORD_W-1]);
    assign lt_unsigned = reg1_i < reg2_i;

    assign shamt    = reg1_i[SHAMT_W-1:0];
    assign lead_cnt = lead_zeros((aluop_i == OP_CLO) ? ~reg1_i : reg1_i);

    assign wide_sum = (aluop_i == OP_SUB)
                      ? ({reg1_i[WORD_W-1], reg1_i} - {reg2_i[WORD_W-1], reg2_i})
                      : ({reg1_i[WORD_W-1], reg1_i} + {reg2_i[WORD_W-1], reg2_i});

    always_comb begin
        case (aluop_i)
            OP_AND:  logic_res_o = reg1_i & reg2_i;
            OP_OR:   logic_res_o = reg1_i | reg2_i;
            OP_XOR:  logic_res_o = reg1_i ^ reg2_i;
            OP_NOR:  logic_res_o = ~(reg1_i | reg2_i);
            default: logic_res_o = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            OP_SLL:  shift_res_o = reg2_i << shamt;
            OP_SRL:  shift_res_o = reg2_i >> shamt;
            OP_SRA:  shift_res_o = word_t'($signed(reg2_i) >>> shamt);  // sign filled
            default: shift_res_o = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: arith_res_o = sum;
            OP_SLT:           arith_res_o = word_t'(lt_signed);
            OP_SLTU:          arith_res_o = word_t'(lt_unsigned);
            OP_CLZ, OP_CLO:   arith_res_o = word_t'(lead_cnt);
            default:          arith_res_o = '0;
        endcase
    end

    // overflow only for signed add/sub, and only when the wide result does not fit
    always_comb begin
        assert final (ov_o == ((aluop_i inside {OP_ADD, OP_SUB})
                               && (wide_sum[WORD_W] != wide_sum[WORD_W-1])))
            else $error("alu_int: overflow flag wrong for op %s", aluop_i.name());
    end

endmodule

`default_nettype wire

// File: verilog/ex_op_pkg.sv
// execute stage operation codes
// op encodings follow the decode stage; the result class is
// derived here from the op instead of a separate select field

`default_nettype none

package ex_op_pkg;

    typedef enum logic [7:0] {
        OP_NOP   = 8'b0000_0000,
        OP_AND   = 8'b0010_0100,
        OP_OR    = 8'b0010_0101,
        OP_XOR   = 8'b0010_0110,
        OP_NOR   = 8'b0010_0111,
        OP_SLL   = 8'b0111_1100,
        OP_SRL   = 8'b0000_0010,
        OP_SRA   = 8'b0000_0011,
        OP_SLT   = 8'b0010_1010,
        OP_SLTU  = 8'b0010_1011,
        OP_ADD   = 8'b0010_0000,
        OP_ADDU  = 8'b0010_0001,
        OP_SUB   = 8'b0010_0010,
        OP_SUBU  = 8'b0010_0011,
        OP_CLZ   = 8'b1011_0000,
        OP_CLO   = 8'b1011_0001,
        OP_MULT  = 8'b0001_1000,
        OP_MULTU = 8'b0001_1001,
        OP_MUL   = 8'b1010_1001,
        OP_MADD  = 8'b1010_0110,
        OP_MADDU = 8'b1010_1000,
        OP_MSUB  = 8'b1010_1010,
        OP_MSUBU = 8'b1010_1011,
        OP_MFHI  = 8'b0001_0000,
        OP_MTHI  = 8'b0001_0001,
        OP_MFLO  = 8'b0001_0010,
        OP_MTLO  = 8'b0001_0011
    } aluop_e;

    typedef enum logic [2:0] {
        LOGIC = 3'd0,
        SHIFT = 3'd1,
        ARITH = 3'd2,
        MUL   = 3'd3,
        MOVE  = 3'd4,
        NONE  = 3'd5
    } res_class_e;

    // which result bus feeds wdata for a given op
    function automatic res_class_e op_class(input aluop_e op);
        res_class_e cls;
        case (op)
            OP_AND, OP_OR, OP_XOR, OP_NOR: cls = LOGIC;
            OP_SLL, OP_SRL, OP_SRA:        cls = SHIFT;
            OP_SLT, OP_SLTU, OP_ADD, OP_ADDU,
            OP_SUB, OP_SUBU, OP_CLZ, OP_CLO: cls = ARITH;
            OP_MUL, OP_MULT, OP_MULTU,
            OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU: cls = MUL;
            OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO: cls = MOVE;
            default:                       cls = NONE;
        endcase
        return cls;
    endfunction

    // two-cycle multiply-accumulate ops
    function automatic logic is_mac_op(input aluop_e op);
        return op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    endfunction

endpackage

`default_nettype wire

// File: verilog/ex_result_if.sv
// execute result bundle
// one registered stage result plus its HI/LO write request,
// live for a single cycle while valid is high

`timescale 1ns/1ps
`default_nettype none

interface ex_result_if;
    import ex_types_pkg::*;

    logic      valid;     // result present this cycle
    reg_addr_t wd;        // destination register
    logic      wreg;      // write general register
    word_t     wdata;
    logic      whilo;     // write HI/LO pair
    word_t     hi;
    word_t     lo;
    logic      overflow;  // signed add/sub overflow

    modport source (
        output valid, wd, wreg, wdata, whilo, hi, lo, overflow
    );

    modport sink (
        input valid, wd, wreg, wdata, whilo, hi, lo, overflow
    );

endinterface

`default_nettype wire

// File: verilog/ex_result_stage.sv
// execute result stage
// selects wdata by op class, builds the HI/LO write request,
// drops the register write on overflow and registers the result

`timescale 1ns/1ps
`default_nettype none

module ex_result_stage (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     valid_i,
    input  ex_op_pkg::aluop_e        aluop_i,
    input  ex_types_pkg::word_t      reg1_i,
    input  ex_types_pkg::reg_addr_t  wd_i,
    input  logic                     wreg_i,
    input  ex_types_pkg::word_t      logic_res_i,
    input  ex_types_pkg::word_t      shift_res_i,
    input  ex_types_pkg::word_t      arith_res_i,
    input  logic                     ov_i,
    input  ex_types_pkg::dword_t     mul_res_i,
    input  logic                     mac_done_i,
    input  ex_types_pkg::dword_t     mac_res_i,
    input  ex_types_pkg::word_t      hi_fwd_i,
    input  ex_types_pkg::word_t      lo_fwd_i,
    ex_result_if.source              res
);
    import ex_types_pkg::*;
    import ex_op_pkg::*;

    res_class_e cls;
    logic       mac_issue;
    logic       valid_n;
    word_t      wdata_n;
    logic       whilo_n;
    word_t      hi_n;
    word_t      lo_n;
    reg_addr_t  mac_wd_q;    // destination held over the busy cycle
    logic       mac_wreg_q;

    assign cls       = op_class(aluop_i);
    assign mac_issue = valid_i && is_mac_op(aluop_i);
    assign valid_n   = (valid_i && !is_mac_op(aluop_i)) || mac_done_i;

    always_comb begin
        case (cls)
            LOGIC:   wdata_n = logic_res_i;
            SHIFT:   wdata_n = shift_res_i;
            ARITH:   wdata_n = arith_res_i;
            MUL:     wdata_n = mul_res_i[WORD_W-1:0];  // mul keeps the low word
            MOVE: begin
                if (aluop_i == OP_MFHI) begin
                    wdata_n = hi_fwd_i;
                end else if (aluop_i == OP_MFLO) begin
                    wdata_n = lo_fwd_i;
                end else begin
                    wdata_n = '0;
                end
            end
            default: wdata_n = '0;
        endcase
    end

    always_comb begin
        whilo_n = 1'b0;
        hi_n    = '0;
        lo_n    = '0;
        if (mac_done_i) begin
            whilo_n      = 1'b1;
            {hi_n, lo_n} = mac_res_i;
        end else begin
            case (aluop_i)
                OP_MULT, OP_MULTU: begin
                    whilo_n      = 1'b1;
                    {hi_n, lo_n} = mul_res_i;
                end
                OP_MTHI: begin
                    whilo_n = 1'b1;
                    hi_n    = reg1_i;
                    lo_n    = lo_fwd_i;  // LO unchanged
                end
                OP_MTLO: begin
                    whilo_n = 1'b1;
                    hi_n    = hi_fwd_i;
                    lo_n    = reg1_i;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res.valid    <= 1'b0;
            res.wreg     <= 1'b0;
            res.whilo    <= 1'b0;
            res.overflow <= 1'b0;
            mac_wreg_q   <= 1'b0;
        end else begin
            res.valid    <= valid_n;
            res.wreg     <= valid_n && (mac_done_i ? mac_wreg_q : (wreg_i && !ov_i));
            res.whilo    <= valid_n && whilo_n;
            res.overflow <= valid_n && !mac_done_i && ov_i;
            if (mac_issue) begin
                mac_wreg_q <= wreg_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        res.wd    <= mac_done_i ? mac_wd_q : wd_i;
        res.wdata <= mac_done_i ? '0 : wdata_n;
        res.hi    <= hi_n;
        res.lo    <= lo_n;
        if (mac_issue) begin
            mac_wd_q <= wd_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ex_top.sv
// execute stage top level
// ALU, multiplier, HI/LO file and result register behind one
// issue port; the registered result is copied to the outputs

`timescale 1ns/1ps
`default_nettype none

module ex_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    valid_i,
    input  ex_op_pkg::aluop_e       aluop_i,
    input  ex_types_pkg::word_t     reg1_i,
    input  ex_types_pkg::word_t     reg2_i,
    input  ex_types_pkg::reg_addr_t wd_i,
    input  logic                    wreg_i,
    output logic                    valid_o,
    output ex_types_pkg::reg_addr_t wd_o,
    output logic                    wreg_o,
    output ex_types_pkg::word_t     wdata_o,
    output logic                    whilo_o,
    output ex_types_pkg::word_t     hi_o,
    output ex_types_pkg::word_t     lo_o,
    output logic                    overflow_o,
    output logic                    stall_o
);
    import ex_types_pkg::*;

    word_t  logic_res;
    word_t  shift_res;
    word_t  arith_res;
    logic   ov;
    dword_t mul_res;
    logic   mac_done;
    dword_t mac_res;
    word_t  hi_fwd;
    word_t  lo_fwd;

    ex_result_if res_if ();

    alu_int u_alu (
        .aluop_i     (aluop_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .logic_res_o (logic_res),
        .shift_res_o (shift_res),
        .arith_res_o (arith_res),
        .ov_o        (ov)
    );

    mul_unit u_mul (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .aluop_i    (aluop_i),
        .reg1_i     (reg1_i),
        .reg2_i     (reg2_i),
        .hi_fwd_i   (hi_fwd),
        .lo_fwd_i   (lo_fwd),
        .mul_res_o  (mul_res),
        .mac_done_o (mac_done),
        .mac_res_o  (mac_res),
        .stall_o    (stall_o)
    );

    hilo_file u_hilo (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .res      (res_if.sink),
        .hi_fwd_o (hi_fwd),
        .lo_fwd_o (lo_fwd)
    );

    ex_result_stage u_res (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .aluop_i     (aluop_i),
        .reg1_i      (reg1_i),
        .wd_i        (wd_i),
        .wreg_i      (wreg_i),
        .logic_res_i (logic_res),
        .shift_res_i (shift_res),
        .arith_res_i (arith_res),
        .ov_i        (ov),
        .mul_res_i   (mul_res),
        .mac_done_i  (mac_done),
        .mac_res_i   (mac_res),
        .hi_fwd_i    (hi_fwd),
        .lo_fwd_i    (lo_fwd),
        .res         (res_if.source)
    );

    assign valid_o    = res_if.valid;
    assign wd_o       = res_if.wd;
    assign wreg_o     = res_if.wreg;
    assign wdata_o    = res_if.wdata;
    assign whilo_o    = res_if.whilo;
    assign hi_o       = res_if.hi;
    assign lo_o       = res_if.lo;
    assign overflow_o = res_if.overflow;

endmodule

`default_nettype wire

// File: verilog/ex_types_pkg.sv
// execute stage data types
// word, double word and register address widths shared by
// the datapath, the HI/LO file and the result interface

`default_nettype none

package ex_types_pkg;

    localparam int WORD_W     = 32;  // data path width
    localparam int REG_ADDR_W = 5;   // 32 general registers
    localparam int SHAMT_W    = 5;   // reg1 bits used as shift amount

    // one general register value
    typedef logic [WORD_W-1:0] word_t;

    // {HI, LO} pair or a full product
    typedef logic [2*WORD_W-1:0] dword_t;

    // destination register number
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage

`default_nettype wire

// File: verilog/hilo_file.sv
// HI/LO register pair
// written from the registered stage result, with a bypass so a
// reader in the same cycle as the pending write sees the new value

`timescale 1ns/1ps
`default_nettype none

module hilo_file (
    input  logic                clk,
    input  logic                rst_n_i,
    ex_result_if.sink           res,
    output ex_types_pkg::word_t hi_fwd_o,
    output ex_types_pkg::word_t lo_fwd_o
);
    import ex_types_pkg::*;

    word_t hi_q;
    word_t lo_q;
    logic  wr_en;

    assign wr_en = res.valid && res.whilo;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (wr_en) begin
            hi_q <= res.hi;
            lo_q <= res.lo;
        end
    end

    // pending write wins over the stored pair
    assign hi_fwd_o = wr_en ? res.hi : hi_q;
    assign lo_fwd_o = wr_en ? res.lo : lo_q;

endmodule

`default_nettype wire

// File: verilog/mul_unit.sv
// multiplier of the execute stage
// signed/unsigned 32x32 product, and a two-cycle sequencer for
// madd/maddu/msub/msubu that stalls the issuer for one cycle

`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  ex_op_pkg::aluop_e    aluop_i,
    input  ex_types_pkg::word_t  reg1_i,
    input  ex_types_pkg::word_t  reg2_i,
    input  ex_types_pkg::word_t  hi_fwd_i,
    input  ex_types_pkg::word_t  lo_fwd_i,
    output ex_types_pkg::dword_t mul_res_o,
    output logic                 mac_done_o,
    output ex_types_pkg::dword_t mac_res_o,
    output logic                 stall_o
);
    import ex_types_pkg::*;
    import ex_op_pkg::*;

    typedef enum logic {
        MAC_IDLE = 1'b0,
        MAC_BUSY = 1'b1
    } mac_state_e;

    mac_state_e state_q;
    logic       signed_op;
    logic       neg_prod;    // operand signs differ
    logic       busy;
    word_t      op_a;
    word_t      op_b;
    dword_t     prod_mag;
    dword_t     mac_prod_q;  // product captured at issue

    assign signed_op = aluop_i inside {OP_MUL, OP_MULT, OP_MADD, OP_MSUB};

    // work on magnitudes, fix the sign afterwards
    assign op_a = (signed_op && reg1_i[WORD_W-1]) ? (~reg1_i + 32'd1) : reg1_i;
    assign op_b = (signed_op && reg2_i[WORD_W-1]) ? (~reg2_i + 32'd1) : reg2_i;

    assign prod_mag = dword_t'(op_a) * dword_t'(op_b);
    assign neg_prod = signed_op && (reg1_i[WORD_W-1] ^ reg2_i[WORD_W-1]);
    assign mul_res_o = neg_prod ? (~prod_mag + 64'd1) : prod_mag;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= MAC_IDLE;
        end else begin
            case (state_q)
                MAC_IDLE: begin
                    if (valid_i && is_mac_op(aluop_i)) begin
                        state_q <= MAC_BUSY;
                    end
                end
                default: state_q <= MAC_IDLE;  // accumulate takes one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == MAC_IDLE && valid_i && is_mac_op(aluop_i)) begin
            if (aluop_i inside {OP_MSUB, OP_MSUBU}) begin
                mac_prod_q <= ~mul_res_o + 64'd1;  // subtract from HI/LO
            end else begin
                mac_prod_q <= mul_res_o;
            end
        end
    end

    assign busy       = (state_q == MAC_BUSY);
    assign stall_o    = busy;
    assign mac_done_o = busy;
    assign mac_res_o  = mac_prod_q + {hi_fwd_i, lo_fwd_i};

    // issuer must hold off while the accumulate completes
    a_no_issue_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n_i) busy |-> !valid_i
    ) else $error("mul_unit: issue during accumulate stall");

    a_busy_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n_i) busy |=> !busy
    ) else $error("mul_unit: accumulate busy for more than one cycle");

endmodule

`default_nettype wire
